// File: hw/xfifo_pkg.sv
package xfifo_pkg;

   // output side machine
   typedef enum logic [1:0] {
      DRAIN_IDLE,
      DRAIN_FETCH,
      DRAIN_PRESENT
   } drain_state_t;

   // saturating dropped byte counter
   localparam int DROP_CNT_W = 16;

   // gray to binary by prefix xor, upper zero bits leave the result unchanged
   function automatic logic [31:0] gray_to_bin(input logic [31:0] gray);
      logic [31:0] bin;
      bin[31] = gray[31];
      for (int i = 30; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// File: hw/fifo_if.sv
`timescale 1ns/1ps

// write port of the fifo, lives in the write clock domain
interface fifo_wr_if #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
);
   logic              en;
   logic [DATA_W-1:0] data;
   logic              full;
   logic [ADDR_W-1:0] level;

   modport src (
      output en,
      output data,
      input  full,
      input  level
   );

   modport fifo (
      input  en,
      input  data,
      output full,
      output level
   );
endinterface

// read port of the fifo, lives in the read clock domain
interface fifo_rd_if #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 4
);
   logic              en;
   logic [DATA_W-1:0] data;
   logic              empty;
   logic [ADDR_W-1:0] level;

   modport sink (
      output en,
      input  data,
      input  empty,
      input  level
   );

   modport fifo (
      input  en,
      output data,
      output empty,
      output level
   );
endinterface

// File: hw/gray_counter.sv
`timescale 1ns/1ps

module gray_counter #(
   parameter int WIDTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [WIDTH-1:0] count
);

   // binary runs one ahead of the gray register
   logic [WIDTH-1:0] bin_q;
   logic [WIDTH-1:0] gray_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_q  <= WIDTH'(1);
         gray_q <= '0;
      end else if (en) begin
         bin_q  <= bin_q + 1'b1;
         gray_q <= bin_q ^ (bin_q >> 1);
      end
   end

   assign count = gray_q;

endmodule

// File: hw/ptr_sync.sv
`timescale 1ns/1ps

module ptr_sync
   import xfifo_pkg::*;
#(
   parameter int WIDTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] gray_in,
   output logic [WIDTH-1:0] bin_out
);

   // two stage synchronizer, only one bit of a gray pointer moves at a time
   logic [WIDTH-1:0] sync_q1;
   logic [WIDTH-1:0] sync_q2;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= gray_in;
         sync_q2 <= sync_q1;
      end
   end

   // binary pointer for the receiving domain
   assign bin_out = WIDTH'(gray_to_bin(32'(sync_q2)));

endmodule

// File: hw/asym_dp_ram.sv
`timescale 1ns/1ps

module asym_dp_ram #(
   parameter int W_DATA_W = 8,
   parameter int W_ADDR_W = 6,
   parameter int R_DATA_W = 32,
   parameter int R_ADDR_W = 4
) (
   input  logic                w_clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic                r_clk,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // storage is kept at the narrow width
   localparam int MIN_W      = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MAX_ADDR_W = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int W_RATIO    = W_DATA_W / MIN_W;
   localparam int R_RATIO    = R_DATA_W / MIN_W;
   localparam int W_SHIFT    = $clog2(W_RATIO);
   localparam int R_SHIFT    = $clog2(R_RATIO);
   localparam int DEPTH      = 1 << MAX_ADDR_W;

   logic [MIN_W-1:0]      mem [0:DEPTH-1];
   logic [MAX_ADDR_W-1:0] w_base;
   logic [MAX_ADDR_W-1:0] r_base;

   // first narrow entry touched by each port
   assign w_base = MAX_ADDR_W'(w_addr) << W_SHIFT;
   assign r_base = MAX_ADDR_W'(r_addr) << R_SHIFT;

   // a wide write splits into consecutive entries, low lane first
   always_ff @(posedge w_clk) begin
      if (w_en) begin
         for (int i = 0; i < W_RATIO; i++) begin
            mem[w_base + MAX_ADDR_W'(i)] <= w_data[i*MIN_W +: MIN_W];
         end
      end
   end

   // wide read gathers entries, lowest address in the lsb lane
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         for (int j = 0; j < R_RATIO; j++) begin
            r_data[j*MIN_W +: MIN_W] <= mem[r_base + MAX_ADDR_W'(j)];
         end
      end
   end

endmodule

// File: hw/async_fifo_asym.sv
`timescale 1ns/1ps

module async_fifo_asym
   import xfifo_pkg::*;
#(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  logic   rst,
   input  logic   w_clk,
   input  logic   r_clk,
   fifo_wr_if.fifo wr,
   fifo_rd_if.fifo rd
);

   // ADDR_W counts narrow entries, the wide side needs fewer address bits
   localparam int MAX_W      = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W      = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int RATIO_BITS = $clog2(MAX_W / MIN_W);
   localparam int L_ADDR_W   = ADDR_W - RATIO_BITS;
   localparam int W_ADDR_W   = (W_DATA_W >= R_DATA_W) ? L_ADDR_W : ADDR_W;
   localparam int R_ADDR_W   = (R_DATA_W >= W_DATA_W) ? L_ADDR_W : ADDR_W;
   localparam int W_DEPTH    = 1 << W_ADDR_W;

   logic                w_en_eff;
   logic [W_ADDR_W-1:0] w_ptr_gray;
   logic [W_ADDR_W-1:0] w_ptr_bin;
   logic [R_ADDR_W-1:0] r_ptr_sync_bin;
   logic [W_ADDR_W-1:0] r_ptr_in_w;

   logic                r_en_eff;
   logic [R_ADDR_W-1:0] r_ptr_gray;
   logic [R_ADDR_W-1:0] r_ptr_bin;
   logic [W_ADDR_W-1:0] w_ptr_sync_bin;
   logic [R_ADDR_W-1:0] w_ptr_in_r;

   // align foreign pointers to the local granularity
   generate
      if (W_ADDR_W > R_ADDR_W) begin : g_narrow_wr
         assign r_ptr_in_w = {r_ptr_sync_bin, {RATIO_BITS{1'b0}}};
         assign w_ptr_in_r = w_ptr_sync_bin[W_ADDR_W-1:RATIO_BITS];
      end else if (W_ADDR_W == R_ADDR_W) begin : g_equal
         assign r_ptr_in_w = r_ptr_sync_bin;
         assign w_ptr_in_r = w_ptr_sync_bin;
      end else begin : g_wide_wr
         assign r_ptr_in_w = r_ptr_sync_bin[R_ADDR_W-1:RATIO_BITS];
         assign w_ptr_in_r = {w_ptr_sync_bin, {RATIO_BITS{1'b0}}};
      end
   endgenerate

   // write domain
   assign w_en_eff  = wr.en & ~wr.full;
   assign w_ptr_bin = W_ADDR_W'(gray_to_bin(32'(w_ptr_gray)));
   assign wr.level  = w_ptr_bin - r_ptr_in_w;
   assign wr.full   = (wr.level == W_ADDR_W'(W_DEPTH - 1));

   gray_counter #(.WIDTH(W_ADDR_W)) u_w_ptr (
      .clk   (w_clk),
      .rst   (rst),
      .en    (w_en_eff),
      .count (w_ptr_gray)
   );

   ptr_sync #(.WIDTH(R_ADDR_W)) u_r_ptr_sync (
      .clk     (w_clk),
      .rst     (rst),
      .gray_in (r_ptr_gray),
      .bin_out (r_ptr_sync_bin)
   );

   // read domain, level counts whole read words only
   assign r_en_eff  = rd.en & ~rd.empty;
   assign r_ptr_bin = R_ADDR_W'(gray_to_bin(32'(r_ptr_gray)));
   assign rd.level  = w_ptr_in_r - r_ptr_bin;
   assign rd.empty  = (rd.level == '0);

   gray_counter #(.WIDTH(R_ADDR_W)) u_r_ptr (
      .clk   (r_clk),
      .rst   (rst),
      .en    (r_en_eff),
      .count (r_ptr_gray)
   );

   ptr_sync #(.WIDTH(W_ADDR_W)) u_w_ptr_sync (
      .clk     (r_clk),
      .rst     (rst),
      .gray_in (w_ptr_gray),
      .bin_out (w_ptr_sync_bin)
   );

   asym_dp_ram #(
      .W_DATA_W (W_DATA_W),
      .W_ADDR_W (W_ADDR_W),
      .R_DATA_W (R_DATA_W),
      .R_ADDR_W (R_ADDR_W)
   ) u_ram (
      .w_clk  (w_clk),
      .w_en   (w_en_eff),
      .w_addr (w_ptr_bin),
      .w_data (wr.data),
      .r_clk  (r_clk),
      .r_en   (r_en_eff),
      .r_addr (r_ptr_bin),
      .r_data (rd.data)
   );

endmodule

// File: hw/byte_ingest.sv
`timescale 1ns/1ps

module byte_ingest
   import xfifo_pkg::*;
#(
   parameter int DATA_W = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  in_valid,
   input  logic [DATA_W-1:0]     in_data,
   fifo_wr_if.src                wr,
   output logic [DROP_CNT_W-1:0] drop_count
);

   logic drop;

   // a byte that meets a full fifo is lost
   assign drop = in_valid & wr.full;

   // forward accepted bytes in the same cycle
   assign wr.en   = in_valid & ~wr.full;
   assign wr.data = in_data;

   // counter sticks at its maximum
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         drop_count <= '0;
      end else if (drop && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

endmodule

// File: hw/word_drain.sv
`timescale 1ns/1ps

module word_drain
   import xfifo_pkg::*;
#(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              out_en,
   fifo_rd_if.sink           rd,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data
);

   drain_state_t state;
   drain_state_t state_next;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= DRAIN_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // one word per pass, idle -> fetch -> present
   always_comb begin
      state_next = state;
      case (state)
         DRAIN_IDLE: begin
            if (out_en && !rd.empty) begin
               state_next = DRAIN_FETCH;
            end
         end
         DRAIN_FETCH: begin
            state_next = DRAIN_PRESENT;
         end
         DRAIN_PRESENT: begin
            state_next = DRAIN_IDLE;
         end
         default: begin
            state_next = DRAIN_IDLE;
         end
      endcase
   end

   // read strobe for the single fetch cycle
   assign rd.en = (state == DRAIN_FETCH);

   // ram output register holds the fetched word from here on
   assign out_valid = (state == DRAIN_PRESENT);
   assign out_data  = rd.data;

endmodule

// File: hw/xfifo_top.sv
`timescale 1ns/1ps

module xfifo_top
   import xfifo_pkg::*;
#(
   parameter int IN_W   = 8,
   parameter int OUT_W  = 32,
   parameter int ADDR_W = 6
) (
   input  logic                                   clk,
   input  logic                                   r_clk,
   input  logic                                   rst,
   input  logic                                   in_valid,
   input  logic [IN_W-1:0]                        in_data,
   input  logic                                   out_en,
   output logic                                   out_valid,
   output logic [OUT_W-1:0]                       out_data,
   output logic [DROP_CNT_W-1:0]                  drop_count,
   output logic [ADDR_W-1:0]                      w_level,
   output logic [ADDR_W-$clog2(OUT_W/IN_W)-1:0]  r_level
);

   // word side address width
   localparam int R_ADDR_W = ADDR_W - $clog2(OUT_W / IN_W);

   fifo_wr_if #(.DATA_W(IN_W), .ADDR_W(ADDR_W)) wr_if ();
   fifo_rd_if #(.DATA_W(OUT_W), .ADDR_W(R_ADDR_W)) rd_if ();

   byte_ingest #(.DATA_W(IN_W)) u_ingest (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .wr         (wr_if.src),
      .drop_count (drop_count)
   );

   async_fifo_asym #(
      .W_DATA_W (IN_W),
      .R_DATA_W (OUT_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo (
      .rst   (rst),
      .w_clk (clk),
      .r_clk (r_clk),
      .wr    (wr_if.fifo),
      .rd    (rd_if.fifo)
   );

   word_drain #(.DATA_W(OUT_W)) u_drain (
      .clk       (r_clk),
      .rst       (rst),
      .out_en    (out_en),
      .rd        (rd_if.sink),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   assign w_level = wr_if.level;
   assign r_level = rd_if.level;

endmodule

// File: verif/xfifo_asserts.sv
`timescale 1ns/1ps

module xfifo_asserts (
   input logic w_clk,
   input logic r_clk,
   input logic rst,
   input logic w_en,
   input logic full,
   input logic r_en,
   input logic empty,
   input logic out_valid
);

   a_no_write_full: assert property (@(posedge w_clk) disable iff (rst) w_en |-> !full)
      else $error("write accepted while the fifo was full");

   a_no_read_empty: assert property (@(posedge r_clk) disable iff (rst) r_en |-> !empty)
      else $error("read issued while the fifo was empty");

   // word is presented one cycle after its fetch
   a_valid_after_read: assert property (@(posedge r_clk) disable iff (rst)
      out_valid |-> $past(r_en))
      else $error("out_valid without a read strobe in the previous cycle");

   a_single_strobe: assert property (@(posedge r_clk) disable iff (rst) r_en |=> !r_en)
      else $error("read strobe held for two cycles");

endmodule

// fifo side, effective enables against occupancy from the raw pointers of both domains
bind async_fifo_asym xfifo_asserts u_fifo_asserts (
   .w_clk     (w_clk),
   .r_clk     (r_clk),
   .rst       (rst),
   .w_en      (w_en_eff),
   .full      ((w_ptr_bin - (W_ADDR_W'(r_ptr_bin) << RATIO_BITS)) == W_ADDR_W'(W_DEPTH - 1)),
   .r_en      (r_en_eff),
   .empty     ((w_ptr_bin >> RATIO_BITS) == W_ADDR_W'(r_ptr_bin)),
   .out_valid (1'b0)
);

// drain side, only the read port exists here
bind word_drain xfifo_asserts u_drain_asserts (
   .w_clk     (1'b0),
   .r_clk     (clk),
   .rst       (rst),
   .w_en      (1'b0),
   .full      (1'b0),
   .r_en      (rd.en),
   .empty     (rd.empty),
   .out_valid (out_valid)
);

// File: verif/xfifo_tb.sv
`timescale 1ns/1ps

module xfifo_tb;

   localparam logic [31:0] SEED = 32'hef8d8ff6;
   localparam int N_ROWS = 5;

   typedef struct packed {
      logic [7:0] n_bytes;
      logic       rand_gap;
      logic       en_low;
      logic [7:0] drops;
   } row_t;

   // bytes, random gaps, out_en low during writes, expected drops
   localparam row_t ROWS [N_ROWS] = '{
      '{8'd32, 1'b0, 1'b0, 8'd0},
      '{8'd30, 1'b1, 1'b0, 8'd0},
      '{8'd18, 1'b1, 1'b0, 8'd0},
      '{8'd20, 1'b0, 1'b1, 8'd0},
      '{8'd72, 1'b0, 1'b1, 8'd9}
   };
   string row_names [N_ROWS] = '{
      "b2b_en_high", "rand_gap_partial", "rand_gap_complete", "levels_en_low", "overflow"
   };

   logic        clk = 1'b0;
   logic        r_clk = 1'b0;
   logic        rst;
   logic        in_valid;
   logic [7:0]  in_data;
   logic        out_en;
   logic        out_valid;
   logic [31:0] out_data;
   logic [15:0] drop_count;
   logic [5:0]  w_level;
   logic [3:0]  r_level;

   logic [7:0]  sb [$];
   logic [31:0] exp_word;
   int          errors = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   int          words_read = 0;

   always #4 clk = ~clk;
   always #6 r_clk = ~r_clk;

   xfifo_top #(.IN_W(8), .OUT_W(32), .ADDR_W(6)) UUT (
      .clk        (clk),
      .r_clk      (r_clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .out_en     (out_en),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .drop_count (drop_count),
      .w_level    (w_level),
      .r_level    (r_level)
   );

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("error %s expected 0x%0h actual 0x%0h", name, exp, act);
         errors++;
      end
   endtask

   // lets both pointers cross before levels are compared
   task automatic wait_settle();
      repeat (6) @(posedge r_clk);
      @(posedge clk);
   endtask

   task automatic report_test(input string name, input int errs_start);
      if (errors == errs_start) begin
         n_pass++;
         $display("test %-18s ok", name);
      end else begin
         n_fail++;
         $display("test %-18s failed with %0d errors", name, errors - errs_start);
      end
   endtask

   // each word is four queued bytes, first byte in the low lane
   always @(posedge r_clk) begin
      if (out_valid) begin
         assert (sb.size() >= 4) else begin
            $display("out_valid was high with no complete word left to deliver");
            errors++;
         end
         if (sb.size() >= 4) begin
            exp_word = {sb[3], sb[2], sb[1], sb[0]};
            repeat (4) void'(sb.pop_front());
            words_read++;
            check_value("out_data", exp_word, out_data);
         end
      end
   end

   initial begin
      int total;
      total = 0;
      for (int i = 0; i < N_ROWS; i++) begin
         total += int'(ROWS[i].n_bytes);
      end
      #(total * 40 + 5000);
      $display("timeout, the run did not finish within %0d ns", total * 40 + 5000);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      logic [7:0] b;
      int gap;
      int errs_start;
      int words_start;
      int drops_exp;
      void'($urandom(SEED));
      rst = 1'b1;
      in_valid = 1'b0;
      in_data = 8'h00;
      out_en = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      errs_start = errors;
      check_value("out_valid", 32'd0, 32'(out_valid));
      check_value("drop_count", 32'd0, 32'(drop_count));
      check_value("w_level", 32'd0, 32'(w_level));
      check_value("r_level", 32'd0, 32'(r_level));
      repeat (10) @(posedge r_clk);
      report_test("reset_state", errs_start);

      drops_exp = 0;
      for (int t = 0; t < N_ROWS; t++) begin
         errs_start = errors;
         drops_exp += int'(ROWS[t].drops);
         @(posedge clk);
         out_en <= ~ROWS[t].en_low;
         words_start = words_read;
         for (int k = 0; k < int'(ROWS[t].n_bytes); k++) begin
            b = 8'($urandom);
            gap = ROWS[t].rand_gap ? int'($urandom_range(3, 0)) : 0;
            @(posedge clk);
            in_valid <= 1'b1;
            in_data <= b;
            // a byte is lost once 63 bytes sit in the fifo
            if (sb.size() < 63) begin
               sb.push_back(b);
            end
            repeat (gap) begin
               @(posedge clk);
               in_valid <= 1'b0;
            end
         end
         @(posedge clk);
         in_valid <= 1'b0;
         @(posedge clk);
         check_value("drop_count", 32'(drops_exp), 32'(drop_count));
         if (ROWS[t].en_low) begin
            check_value("w_level", 32'(sb.size()), 32'(w_level));
            wait_settle();
            check_value("r_level", 32'(sb.size() / 4), 32'(r_level));
            assert (words_read == words_start) else begin
               $display("a word was delivered while out_en was low");
               errors++;
            end
            @(posedge clk);
            out_en <= 1'b1;
         end
         while (sb.size() >= 4) begin
            @(posedge r_clk);
         end
         wait_settle();
         check_value("w_level", 32'(sb.size()), 32'(w_level));
         check_value("r_level", 32'(sb.size() / 4), 32'(r_level));
         report_test(row_names[t], errs_start);
      end

      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: flist.f
hw/xfifo_pkg.sv
hw/fifo_if.sv
hw/gray_counter.sv
hw/ptr_sync.sv
hw/asym_dp_ram.sv
hw/async_fifo_asym.sv
hw/byte_ingest.sv
hw/word_drain.sv
hw/xfifo_top.sv
verif/xfifo_asserts.sv
verif/xfifo_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module xfifo_tb -f flist.f -o xfifo_sim
	./obj_dir/xfifo_sim | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir
